// ==== common/soc_macros.svh ====
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Reset sequencing, in sys_clk cycles after the last trigger
`define SOC_RST_DEBOUNCE 256
// Flash leaves reset well before the system does
`define SOC_FLASH_RST_WAIT 128

// Value of the ID register
`define SOC_SYSTEM_ID 32'h13004D31

// Monitor RAM word address width
`define SOC_MONITOR_AW 8

// sysctl register indices
`define SOC_REG_GPIO_IN 10'd0
`define SOC_REG_GPIO_OUT 10'd1
`define SOC_REG_IRQ_EN 10'd2
`define SOC_REG_SYSID 10'd3
`define SOC_REG_RESET 10'd4
`define SOC_REG_BUSERR_EN 10'd5
`define SOC_REG_WLOCK 10'd6

// GPIO widths
`define SOC_GPIO_IN_W 7
`define SOC_GPIO_OUT_W 2

`endif

// ==== common/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

	// --------------------------------------------------
	// Wishbone bus
	// --------------------------------------------------

	// Byte address as seen by the master
	typedef logic [31:0] wb_adr_t;

	// Read and write data
	typedef logic [31:0] wb_dat_t;

	// One select per byte lane
	typedef logic [3:0] wb_sel_t;

	// --------------------------------------------------
	// CSR bus
	// --------------------------------------------------

	// Word address, device in 13:10 and register in 9:0
	typedef logic [13:0] csr_adr_t;

	// Register data
	typedef logic [31:0] csr_dat_t;

	// --------------------------------------------------
	// Address decoder
	// --------------------------------------------------

	// Target of the current access
	typedef enum logic [1:0] {
		SLV_NONE    = 2'd0,
		SLV_MONITOR = 2'd1,
		SLV_CSR     = 2'd2
	} slave_e;

endpackage

`default_nettype wire

// ==== hw/reset_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_macros.svh"

module reset_gen (
	input  logic sys_clk,
	input  logic trigger_reset,
	input  logic hard_reset_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	localparam int DEB_W = $clog2(`SOC_RST_DEBOUNCE + 1);
	localparam int FL_W  = $clog2(`SOC_FLASH_RST_WAIT + 1);

	logic             trig_q;
	logic [DEB_W-1:0] debounce_cnt;
	logic [FL_W-1:0]  flash_cnt;

	// External trigger or software soft reset
	always_ff @(posedge sys_clk) begin
		trig_q <= trigger_reset | hard_reset_i;
	end

	// Debounce counter reloads on every trigger
	always_ff @(posedge sys_clk) begin
		if (trig_q) begin
			debounce_cnt <= DEB_W'(`SOC_RST_DEBOUNCE);
		end else if (debounce_cnt != '0) begin
			debounce_cnt <= debounce_cnt - DEB_W'(1);
		end
		sys_rst_o <= trig_q | (debounce_cnt != '0);
	end

	// Flash release counter, saturates at its limit
	always_ff @(posedge sys_clk) begin
		if (trig_q) begin
			flash_cnt <= '0;
		end else if (flash_cnt != FL_W'(`SOC_FLASH_RST_WAIT)) begin
			flash_cnt <= flash_cnt + FL_W'(1);
		end
	end

	assign flash_rst_n_o = (flash_cnt == FL_W'(`SOC_FLASH_RST_WAIT));

	// Flash must be out of reset before the system starts
	a_flash_first: assert property (@(posedge sys_clk) $fell(sys_rst_o) |-> flash_rst_n_o)
		else $error("flash_rst_n_o low when sys_rst_o fell");

endmodule

`default_nettype wire

// ==== hw/wb_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_decoder import soc_pkg::*; (
	input  logic    sys_clk,
	input  logic    sys_rst_i,

	// From the master
	input  wb_adr_t wb_adr_i,
	input  logic    wb_cyc_i,
	input  logic    wb_stb_i,
	output wb_dat_t wb_dat_o,
	output logic    wb_ack_o,
	output logic    wb_err_o,

	// Monitor RAM
	output logic    mon_stb_o,
	input  wb_dat_t mon_dat_i,
	input  logic    mon_ack_i,

	// CSR bridge
	output logic    csr_stb_o,
	input  wb_dat_t csr_dat_i,
	input  logic    csr_ack_i,

	input  logic    buserr_en_i
);

	slave_e slave;
	logic   req;
	logic   null_ack_q;

	// --------------------------------------------------
	// Address decode
	// --------------------------------------------------

	// Bit 31 ignored so every region has a shadow
	always_comb begin
		if (wb_adr_i[30:28] == 3'b001) begin
			slave = SLV_MONITOR;
		end else if (wb_adr_i[30:29] == 2'b11) begin
			slave = SLV_CSR;
		end else begin
			slave = SLV_NONE;
		end
	end

	assign req       = wb_cyc_i & wb_stb_i;
	assign mon_stb_o = req & (slave == SLV_MONITOR);
	assign csr_stb_o = req & (slave == SLV_CSR);

	// --------------------------------------------------
	// Unmapped responder
	// --------------------------------------------------

	// One cycle ack, held off while the previous ack is out
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			null_ack_q <= 1'b0;
		end else begin
			null_ack_q <= req & (slave == SLV_NONE) & ~null_ack_q;
		end
	end

	// Err rides on the null ack
	assign wb_err_o = null_ack_q & buserr_en_i;

	// Return path
	always_comb begin
		unique case (slave)
			SLV_MONITOR: begin
				wb_ack_o = mon_ack_i;
				wb_dat_o = mon_dat_i;
			end
			SLV_CSR: begin
				wb_ack_o = csr_ack_i;
				wb_dat_o = csr_dat_i;
			end
			default: begin
				wb_ack_o = null_ack_q;
				wb_dat_o = '0;
			end
		endcase
	end

	// No response outside a bus cycle
	a_resp_in_cyc: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		(wb_ack_o | wb_err_o) |-> wb_cyc_i)
		else $error("ack or err without cyc");

endmodule

`default_nettype wire

// ==== hw/monitor_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_macros.svh"

module monitor_ram import soc_pkg::*; (
	input  logic    sys_clk,
	input  logic    sys_rst_i,
	input  wb_adr_t adr_i,
	input  wb_dat_t dat_i,
	input  wb_sel_t sel_i,
	input  logic    we_i,
	input  logic    stb_i,
	input  logic    wlock_i,
	output wb_dat_t dat_o,
	output logic    ack_o
);

	localparam int AW = `SOC_MONITOR_AW;

	wb_dat_t       mem [0:(2**AW)-1];
	logic [AW-1:0] word_idx;
	logic          wr_en;

	// Word index from the byte address
	assign word_idx = adr_i[AW+1:2];
	// Locked writes are dropped but still acked
	assign wr_en = stb_i & ~ack_o & we_i & ~wlock_i;

	// Storage with byte lanes
	always_ff @(posedge sys_clk) begin
		for (int b = 0; b < 4; b++) begin
			if (wr_en && sel_i[b]) begin
				mem[word_idx][b*8 +: 8] <= dat_i[b*8 +: 8];
			end
		end
		dat_o <= mem[word_idx];
	end

	// Ack one cycle after stb
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= stb_i & ~ack_o;
		end
	end

endmodule

`default_nettype wire

// ==== csr/csr_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_bridge import soc_pkg::*; (
	input  logic     sys_clk,
	input  logic     sys_rst_i,

	// Wishbone slave side
	input  wb_adr_t  wb_adr_i,
	input  wb_dat_t  wb_dat_i,
	input  logic     wb_we_i,
	input  logic     wb_stb_i,
	output wb_dat_t  wb_dat_o,
	output logic     wb_ack_o,

	// CSR master side
	output csr_adr_t csr_a_o,
	output logic     csr_we_o,
	output csr_dat_t csr_dw_o,
	input  csr_dat_t csr_dr_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_ACK
	} state_e;

	state_e state;

	// Sequencer and strobes
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state    <= ST_IDLE;
			csr_we_o <= 1'b0;
			wb_ack_o <= 1'b0;
		end else begin
			csr_we_o <= 1'b0;
			wb_ack_o <= 1'b0;
			unique case (state)
				ST_IDLE: begin
					// Skip the cycle where our ack is still out
					if (wb_stb_i && !wb_ack_o) begin
						csr_we_o <= wb_we_i;
						state    <= ST_WAIT;
					end
				end
				// Device registers its read data here
				ST_WAIT: state <= ST_ACK;
				ST_ACK: begin
					wb_ack_o <= 1'b1;
					state    <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Address and data payload
	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE) begin
			csr_a_o  <= wb_adr_i[15:2];
			csr_dw_o <= wb_dat_i;
		end
		if (state == ST_ACK) begin
			wb_dat_o <= csr_dr_i;
		end
	end

	// Single write strobe per access, only on a fresh request
	a_we_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		csr_we_o |-> !$past(wb_stb_i, 2))
		else $error("csr_we_o repeated within one access");

endmodule

`default_nettype wire

// ==== csr/sysctl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_macros.svh"

module sysctl import soc_pkg::*; #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  logic                       sys_clk,
	input  logic                       sys_rst_i,

	// CSR slave
	input  csr_adr_t                   csr_a_i,
	input  logic                       csr_we_i,
	input  csr_dat_t                   csr_di_i,
	output csr_dat_t                   csr_do_o,

	// GPIO
	input  logic [`SOC_GPIO_IN_W-1:0]  gpio_i,
	output logic [`SOC_GPIO_OUT_W-1:0] gpio_o,
	output logic                       gpio_irq_o,

	// System control
	output logic                       buserr_en_o,
	output logic                       wlock_o,
	output logic                       hard_reset_o
);

	logic [`SOC_GPIO_IN_W-1:0] gpio_s1;
	logic [`SOC_GPIO_IN_W-1:0] gpio_s2;
	logic [`SOC_GPIO_IN_W-1:0] gpio_prev;
	logic [`SOC_GPIO_IN_W-1:0] irq_en;
	logic                      csr_sel;
	logic [9:0]                reg_idx;

	assign csr_sel = (csr_a_i[13:10] == csr_addr);
	assign reg_idx = csr_a_i[9:0];

	// --------------------------------------------------
	// GPIO input sync and change detect
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		gpio_s1   <= gpio_i;
		gpio_s2   <= gpio_s1;
		gpio_prev <= gpio_s2;
	end

	// --------------------------------------------------
	// Register writes
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_o       <= '0;
			irq_en       <= '0;
			buserr_en_o  <= 1'b0;
			wlock_o      <= 1'b0;
			hard_reset_o <= 1'b0;
			gpio_irq_o   <= 1'b0;
		end else begin
			hard_reset_o <= 1'b0;
			// Edge on any enabled input
			gpio_irq_o <= |((gpio_s2 ^ gpio_prev) & irq_en);
			if (csr_sel && csr_we_i) begin
				case (reg_idx)
					`SOC_REG_GPIO_OUT:  gpio_o <= csr_di_i[`SOC_GPIO_OUT_W-1:0];
					`SOC_REG_IRQ_EN:    irq_en <= csr_di_i[`SOC_GPIO_IN_W-1:0];
					// Any value kicks the reset generator
					`SOC_REG_RESET:     hard_reset_o <= 1'b1;
					`SOC_REG_BUSERR_EN: buserr_en_o <= csr_di_i[0];
					`SOC_REG_WLOCK:     wlock_o <= csr_di_i[0];
					default:            ;
				endcase
			end
		end
	end

	// --------------------------------------------------
	// Register reads
	// --------------------------------------------------

	// Zero unless addressed so devices can be ORed
	always_ff @(posedge sys_clk) begin
		csr_do_o <= '0;
		if (csr_sel) begin
			case (reg_idx)
				`SOC_REG_GPIO_IN:   csr_do_o <= csr_dat_t'(gpio_s2);
				`SOC_REG_GPIO_OUT:  csr_do_o <= csr_dat_t'(gpio_o);
				`SOC_REG_IRQ_EN:    csr_do_o <= csr_dat_t'(irq_en);
				`SOC_REG_SYSID:     csr_do_o <= `SOC_SYSTEM_ID;
				`SOC_REG_BUSERR_EN: csr_do_o <= csr_dat_t'(buserr_en_o);
				`SOC_REG_WLOCK:     csr_do_o <= csr_dat_t'(wlock_o);
				default:            csr_do_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/soc_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_macros.svh"

module soc_top import soc_pkg::*; (
	input  logic                       sys_clk,
	input  logic                       trigger_reset,

	// External Wishbone master port
	input  wb_adr_t                    wb_adr_i,
	input  wb_dat_t                    wb_dat_i,
	input  wb_sel_t                    wb_sel_i,
	input  logic                       wb_we_i,
	input  logic                       wb_cyc_i,
	input  logic                       wb_stb_i,
	output wb_dat_t                    wb_dat_o,
	output logic                       wb_ack_o,
	output logic                       wb_err_o,

	// GPIO
	input  logic [`SOC_GPIO_IN_W-1:0]  gpio_i,
	output logic [`SOC_GPIO_OUT_W-1:0] gpio_o,
	output logic                       gpio_irq_o,

	output logic                       sys_rst_o,
	output logic                       flash_rst_n_o
);

	logic     hard_reset;
	logic     buserr_en;
	logic     wlock;
	logic     mon_stb;
	wb_dat_t  mon_dat;
	logic     mon_ack;
	logic     csrbrg_stb;
	wb_dat_t  csrbrg_dat;
	logic     csrbrg_ack;
	csr_adr_t csr_a;
	logic     csr_we;
	csr_dat_t csr_dw;
	csr_dat_t csr_dr_sysctl;

	// --------------------------------------------------
	// Reset sequencing
	// --------------------------------------------------
	reset_gen rst0 (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.hard_reset_i  (hard_reset),
		.sys_rst_o     (sys_rst_o),
		.flash_rst_n_o (flash_rst_n_o)
	);

	// --------------------------------------------------
	// Wishbone decode and slaves
	// --------------------------------------------------
	wb_decoder dec0 (
		.sys_clk     (sys_clk),
		.sys_rst_i   (sys_rst_o),
		.wb_adr_i    (wb_adr_i),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o),
		.wb_err_o    (wb_err_o),
		.mon_stb_o   (mon_stb),
		.mon_dat_i   (mon_dat),
		.mon_ack_i   (mon_ack),
		.csr_stb_o   (csrbrg_stb),
		.csr_dat_i   (csrbrg_dat),
		.csr_ack_i   (csrbrg_ack),
		.buserr_en_i (buserr_en)
	);

	monitor_ram mon0 (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst_o),
		.adr_i     (wb_adr_i),
		.dat_i     (wb_dat_i),
		.sel_i     (wb_sel_i),
		.we_i      (wb_we_i),
		.stb_i     (mon_stb),
		.wlock_i   (wlock),
		.dat_o     (mon_dat),
		.ack_o     (mon_ack)
	);

	// CSR read data of every device ORs in here
	csr_bridge csrbrg0 (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst_o),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_we_i   (wb_we_i),
		.wb_stb_i  (csrbrg_stb),
		.wb_dat_o  (csrbrg_dat),
		.wb_ack_o  (csrbrg_ack),
		.csr_a_o   (csr_a),
		.csr_we_o  (csr_we),
		.csr_dw_o  (csr_dw),
		.csr_dr_i  (csr_dr_sysctl)
	);

	// --------------------------------------------------
	// CSR devices
	// --------------------------------------------------
	sysctl #(
		.csr_addr (4'h1)
	) sysctl0 (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst_o),
		.csr_a_i      (csr_a),
		.csr_we_i     (csr_we),
		.csr_di_i     (csr_dw),
		.csr_do_o     (csr_dr_sysctl),
		.gpio_i       (gpio_i),
		.gpio_o       (gpio_o),
		.gpio_irq_o   (gpio_irq_o),
		.buserr_en_o  (buserr_en),
		.wlock_o      (wlock),
		.hard_reset_o (hard_reset)
	);

endmodule

`default_nettype wire

// ==== sim/tb_soc.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_macros.svh"

module tb_soc import soc_pkg::*; ();

	// --------------------------------------------------
	// Address map and limits
	// --------------------------------------------------
	localparam wb_adr_t MON_BASE   = 32'h1000_0000;
	localparam wb_adr_t CSR_BASE   = 32'h6000_0000;
	localparam wb_adr_t SYSCTL_OFS = 32'h0000_1000;
	localparam wb_adr_t SHADOW_BIT = 32'h8000_0000;
	// Bits 30:28 = 100, outside both regions
	localparam wb_adr_t NULL_ADR   = 32'h4000_0040;
	localparam int      ACK_TIMEOUT = 32;
	localparam int      IRQ_TIMEOUT = 32;
	localparam int      N_WORDS     = 32;

	logic                       sys_clk;
	logic                       trigger_reset;
	wb_adr_t                    wb_adr;
	wb_dat_t                    wb_dat_w;
	wb_sel_t                    wb_sel;
	logic                       wb_we;
	logic                       wb_cyc;
	logic                       wb_stb;
	wb_dat_t                    wb_dat_o;
	logic                       wb_ack_o;
	logic                       wb_err_o;
	logic [`SOC_GPIO_IN_W-1:0]  gpio_in;
	logic [`SOC_GPIO_OUT_W-1:0] gpio_o;
	logic                       gpio_irq_o;
	logic                       sys_rst_o;
	logic                       flash_rst_n_o;

	// Model state
	wb_dat_t                    ram_model [0:(2**`SOC_MONITOR_AW)-1];
	logic [`SOC_GPIO_OUT_W-1:0] gpio_out_m;
	logic [`SOC_GPIO_IN_W-1:0]  irq_en_m;
	logic                       buserr_m;
	logic                       wlock_m;
	int                         ram_idx [0:N_WORDS-1];

	soc_top dut0 (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.wb_adr_i      (wb_adr),
		.wb_dat_i      (wb_dat_w),
		.wb_sel_i      (wb_sel),
		.wb_we_i       (wb_we),
		.wb_cyc_i      (wb_cyc),
		.wb_stb_i      (wb_stb),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.wb_err_o      (wb_err_o),
		.gpio_i        (gpio_in),
		.gpio_o        (gpio_o),
		.gpio_irq_o    (gpio_irq_o),
		.sys_rst_o     (sys_rst_o),
		.flash_rst_n_o (flash_rst_n_o)
	);

	// 100 ns period
	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// --------------------------------------------------
	// Failure reporting
	// --------------------------------------------------
	task automatic abort(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			abort($sformatf("Mismatch at %0t ns: %s, got %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------

	// Read data the SoC should return for this address
	function automatic wb_dat_t predict_read(input wb_adr_t adr);
		wb_dat_t d;
		d = '0;
		if (adr[30:28] == 3'b001) begin
			d = ram_model[adr[`SOC_MONITOR_AW+1:2]];
		end else if (adr[30:29] == 2'b11 && adr[15:12] == 4'h1) begin
			case (adr[11:2])
				`SOC_REG_GPIO_IN:   d = wb_dat_t'(gpio_in);
				`SOC_REG_GPIO_OUT:  d = wb_dat_t'(gpio_out_m);
				`SOC_REG_IRQ_EN:    d = wb_dat_t'(irq_en_m);
				`SOC_REG_SYSID:     d = `SOC_SYSTEM_ID;
				`SOC_REG_BUSERR_EN: d = wb_dat_t'(buserr_m);
				`SOC_REG_WLOCK:     d = wb_dat_t'(wlock_m);
				default:            d = '0;
			endcase
		end
		return d;
	endfunction

	// Err only for unmapped space with errors enabled
	function automatic logic predict_err(input wb_adr_t adr);
		logic mapped;
		mapped = (adr[30:28] == 3'b001) || (adr[30:29] == 2'b11);
		return !mapped && buserr_m;
	endfunction

	task automatic clear_regs_model();
		gpio_out_m = '0;
		irq_en_m   = '0;
		buserr_m   = 1'b0;
		wlock_m    = 1'b0;
	endtask

	task automatic model_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
		if (adr[30:28] == 3'b001) begin
			// Locked RAM keeps its old word
			if (!wlock_m) begin
				for (int b = 0; b < 4; b++) begin
					if (sel[b]) begin
						ram_model[adr[`SOC_MONITOR_AW+1:2]][b*8 +: 8] = dat[b*8 +: 8];
					end
				end
			end
		end else if (adr[30:29] == 2'b11 && adr[15:12] == 4'h1) begin
			case (adr[11:2])
				`SOC_REG_GPIO_OUT:  gpio_out_m = dat[`SOC_GPIO_OUT_W-1:0];
				`SOC_REG_IRQ_EN:    irq_en_m = dat[`SOC_GPIO_IN_W-1:0];
				`SOC_REG_BUSERR_EN: buserr_m = dat[0];
				`SOC_REG_WLOCK:     wlock_m = dat[0];
				// Soft reset clears the control registers
				`SOC_REG_RESET:     clear_regs_model();
				default:            ;
			endcase
		end
	endtask

	// --------------------------------------------------
	// Response compare
	// --------------------------------------------------
	always @(negedge sys_clk) begin
		if (wb_cyc && wb_stb && wb_ack_o === 1'b1) begin
			if (!wb_we) begin
				expect_equal(wb_dat_o, predict_read(wb_adr), "read data");
			end
			expect_equal(32'(wb_err_o), 32'(predict_err(wb_adr)), "bus error flag");
		end
	end

	// --------------------------------------------------
	// Wishbone master
	// --------------------------------------------------
	task automatic bus_access(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel,
		input logic we, output wb_dat_t rdat, output logic err);
		int waited;
		waited = 0;
		@(posedge sys_clk);
		wb_adr   <= adr;
		wb_dat_w <= dat;
		wb_sel   <= sel;
		wb_we    <= we;
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		@(negedge sys_clk);
		while (wb_ack_o !== 1'b1) begin
			if (waited == ACK_TIMEOUT) begin
				abort($sformatf("No ack for the access to %h within %0d cycles",
					adr, ACK_TIMEOUT));
			end
			waited++;
			@(negedge sys_clk);
		end
		rdat = wb_dat_o;
		err  = wb_err_o;
		// Request drops in the cycle after ack
		@(posedge sys_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
		wb_dat_t rdat;
		logic    err;
		bus_access(adr, dat, sel, 1'b1, rdat, err);
		model_write(adr, dat, sel);
	endtask

	task automatic bus_read(input wb_adr_t adr, output wb_dat_t rdat, output logic err);
		bus_access(adr, '0, 4'hF, 1'b0, rdat, err);
	endtask

	function automatic wb_adr_t ram_adr(input int idx, input logic shadow);
		return MON_BASE | (shadow ? SHADOW_BIT : 32'h0) | (wb_adr_t'(idx) << 2);
	endfunction

	function automatic wb_adr_t reg_adr(input logic [9:0] idx);
		return CSR_BASE | SYSCTL_OFS | {20'b0, idx, 2'b00};
	endfunction

	// --------------------------------------------------
	// Reset and interrupt waits
	// --------------------------------------------------
	task automatic wait_rst_rise(input int limit);
		int n;
		n = 0;
		@(negedge sys_clk);
		while (sys_rst_o !== 1'b1) begin
			if (n == limit) begin
				abort("System reset did not rise within the timeout");
			end
			n++;
			@(negedge sys_clk);
		end
	endtask

	// Flash must already be released when the system leaves reset
	task automatic wait_rst_fall(input int limit);
		int n;
		n = 0;
		@(negedge sys_clk);
		while (sys_rst_o !== 1'b0) begin
			if (n == limit) begin
				abort("System reset did not fall within the timeout");
			end
			expect_equal(32'(wb_ack_o | wb_err_o), 32'd0, "bus response during reset");
			n++;
			@(negedge sys_clk);
		end
		expect_equal(32'(flash_rst_n_o), 32'd1, "flash reset at system release");
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		@(negedge sys_clk);
		while (gpio_irq_o !== 1'b1) begin
			if (n == IRQ_TIMEOUT) begin
				abort("No GPIO interrupt within the timeout");
			end
			n++;
			@(negedge sys_clk);
		end
	endtask

	task automatic count_irq(input int cycles, output int pulses);
		pulses = 0;
		repeat (cycles) begin
			@(negedge sys_clk);
			if (gpio_irq_o === 1'b1) begin
				pulses++;
			end
		end
	endtask

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin
		wb_dat_t rdat;
		logic    rerr;
		int      k;
		int      pulses;

		trigger_reset = 1'b1;
		wb_adr        = '0;
		wb_dat_w      = '0;
		wb_sel        = '0;
		wb_we         = 1'b0;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		gpio_in       = '0;
		clear_regs_model();
		void'($urandom(32'h3005));
		// Spread the test words over the whole RAM
		for (int i = 0; i < N_WORDS; i++) begin
			ram_idx[i] = (i * 37 + 5) % (2**`SOC_MONITOR_AW);
		end

		// Reset order
		repeat (5) @(posedge sys_clk);
		trigger_reset <= 1'b0;
		wait_rst_fall(`SOC_RST_DEBOUNCE + 16);

		// Monitor RAM, full words then byte lanes through the shadow
		for (int i = 0; i < N_WORDS; i++) begin
			bus_write(ram_adr(ram_idx[i], 1'b0), $urandom, 4'hF);
		end
		repeat (48) begin
			k = $urandom_range(0, N_WORDS - 1);
			bus_write(ram_adr(ram_idx[k], 1'($urandom)), $urandom, wb_sel_t'($urandom));
		end
		for (int i = 0; i < N_WORDS; i++) begin
			bus_read(ram_adr(ram_idx[i], 1'b0), rdat, rerr);
			bus_read(ram_adr(ram_idx[i], 1'b1), rdat, rerr);
		end

		// sysctl registers
		bus_read(reg_adr(`SOC_REG_SYSID), rdat, rerr);
		expect_equal(rdat, `SOC_SYSTEM_ID, "system ID");
		repeat (4) begin
			bus_write(reg_adr(`SOC_REG_GPIO_OUT), $urandom, 4'hF);
			expect_equal(32'(gpio_o), 32'(gpio_out_m), "gpio_o pins");
			bus_read(reg_adr(`SOC_REG_GPIO_OUT), rdat, rerr);
		end
		repeat (4) begin
			@(posedge sys_clk);
			gpio_in <= `SOC_GPIO_IN_W'($urandom);
			// Two sync stages before the register sees it
			repeat (5) @(posedge sys_clk);
			bus_read(reg_adr(`SOC_REG_GPIO_IN), rdat, rerr);
		end

		// Write lock
		bus_write(reg_adr(`SOC_REG_WLOCK), 32'h1, 4'hF);
		bus_read(reg_adr(`SOC_REG_WLOCK), rdat, rerr);
		for (int i = 0; i < 8; i++) begin
			bus_write(ram_adr(ram_idx[i], 1'b0), $urandom, 4'hF);
		end
		for (int i = 0; i < 8; i++) begin
			bus_read(ram_adr(ram_idx[i], 1'b0), rdat, rerr);
		end
		bus_write(reg_adr(`SOC_REG_WLOCK), 32'h0, 4'hF);
		for (int i = 0; i < 8; i++) begin
			bus_write(ram_adr(ram_idx[i], 1'b1), $urandom, 4'hF);
			bus_read(ram_adr(ram_idx[i], 1'b0), rdat, rerr);
		end

		// Bus errors, off then on
		bus_read(NULL_ADR, rdat, rerr);
		expect_equal(32'(rerr), 32'd0, "err with bus errors disabled");
		bus_read(NULL_ADR | SHADOW_BIT, rdat, rerr);
		bus_write(reg_adr(`SOC_REG_BUSERR_EN), 32'h1, 4'hF);
		bus_read(NULL_ADR, rdat, rerr);
		expect_equal(32'(rerr), 32'd1, "err with bus errors enabled");
		expect_equal(rdat, 32'h0, "unmapped read data");
		bus_write(NULL_ADR, $urandom, 4'hF);
		bus_read(ram_adr(ram_idx[3], 1'b0), rdat, rerr);
		bus_read(reg_adr(`SOC_REG_SYSID), rdat, rerr);

		// GPIO interrupt on bit 0 only
		bus_write(reg_adr(`SOC_REG_IRQ_EN), 32'h1, 4'hF);
		bus_read(reg_adr(`SOC_REG_IRQ_EN), rdat, rerr);
		@(posedge sys_clk);
		gpio_in <= gpio_in ^ `SOC_GPIO_IN_W'(1);
		wait_irq();
		count_irq(16, pulses);
		expect_equal(32'(pulses), 32'd0, "extra interrupt pulses");
		@(posedge sys_clk);
		gpio_in <= gpio_in ^ `SOC_GPIO_IN_W'(2);
		count_irq(16, pulses);
		expect_equal(32'(pulses), 32'd0, "interrupt from a disabled bit");

		// Soft reset with every control bit set
		bus_write(reg_adr(`SOC_REG_GPIO_OUT), 32'h3, 4'hF);
		bus_write(reg_adr(`SOC_REG_WLOCK), 32'h1, 4'hF);
		bus_write(reg_adr(`SOC_REG_RESET), 32'h1, 4'hF);
		wait_rst_rise(16);
		wait_rst_fall(`SOC_RST_DEBOUNCE + 16);
		expect_equal(32'(gpio_o), 32'd0, "gpio_o after soft reset");
		bus_read(reg_adr(`SOC_REG_GPIO_OUT), rdat, rerr);
		expect_equal(rdat, 32'h0, "GPIO out register after soft reset");
		bus_read(reg_adr(`SOC_REG_WLOCK), rdat, rerr);
		expect_equal(rdat, 32'h0, "write lock after soft reset");
		bus_read(reg_adr(`SOC_REG_BUSERR_EN), rdat, rerr);
		expect_equal(rdat, 32'h0, "bus error enable after soft reset");
		bus_read(reg_adr(`SOC_REG_IRQ_EN), rdat, rerr);
		bus_read(NULL_ADR, rdat, rerr);
		expect_equal(32'(rerr), 32'd0, "err after soft reset");

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+common
common/soc_pkg.sv
hw/reset_gen.sv
hw/wb_decoder.sv
hw/monitor_ram.sv
csr/csr_bridge.sv
csr/sysctl.sv
hw/soc_top.sv
sim/tb_soc.sv

// ==== Makefile ====
TOP = tb_soc
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
